// ==== logic/cam_cfg_pkg.sv ====
`default_nettype none

package cam_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // key and target sizing
    ////////////////////////////////////////////////////////////////////////////

    // default width of a transaction id used as key
    localparam int KEY_WIDTH_DEF = 4;

    // default width of the slave target stored per key
    localparam int TARGET_WIDTH_DEF = 4;

    // lowest storable key, slot index is key minus this
    // keys below it are never stored
    localparam int KEY_BASE = 4;

endpackage : cam_cfg_pkg

`default_nettype wire

// ==== logic/cam_ctrl_pkg.sv ====
`default_nettype none

package cam_ctrl_pkg;

    // update controller states
    typedef enum logic [2:0] {
        UPD_INIT     = 3'd0,
        UPD_IDLE     = 3'd1,
        UPD_INSERT_1 = 3'd2,
        UPD_INSERT_2 = 3'd3,
        UPD_DELETE_1 = 3'd4,
        UPD_DELETE_2 = 3'd5
    } upd_state_e;

    // one access on the shared table port
    typedef enum logic [1:0] {
        OP_NONE   = 2'd0,
        OP_READ   = 2'd1,
        OP_INSERT = 2'd2,
        OP_DELETE = 2'd3
    } tbl_op_e;

endpackage : cam_ctrl_pkg

`default_nettype wire

// ==== logic/cam_table_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cam_table_if #(
    parameter int KEY_WIDTH    = cam_cfg_pkg::KEY_WIDTH_DEF,
    parameter int TARGET_WIDTH = cam_cfg_pkg::TARGET_WIDTH_DEF
);

    localparam int DEPTH      = 2**KEY_WIDTH - cam_cfg_pkg::KEY_BASE;
    localparam int ADDR_WIDTH = $clog2(DEPTH);

    // request side
    cam_ctrl_pkg::tbl_op_e   op;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [TARGET_WIDTH-1:0] target;

    // response side, read data lands one edge after a granted read
    logic                    grant;
    logic                    hit;
    logic [TARGET_WIDTH-1:0] rd_target;

    modport requester (
        output op, addr, target,
        input  grant, hit, rd_target
    );

    modport memory (
        input  op, addr, target,
        output grant, hit, rd_target
    );

endinterface : cam_table_if

`default_nettype wire

// ==== logic/cam_table_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_table_ram #(
    parameter int KEY_WIDTH    = cam_cfg_pkg::KEY_WIDTH_DEF,
    parameter int TARGET_WIDTH = cam_cfg_pkg::TARGET_WIDTH_DEF
) (
    input  logic        clk,
    input  logic        rstn,
    cam_table_if.memory bus
);

    localparam int DEPTH = 2**KEY_WIDTH - cam_cfg_pkg::KEY_BASE;

    logic [DEPTH-1:0]        valid;
    logic [TARGET_WIDTH-1:0] tgt_mem [DEPTH];

    // single port, never busy
    assign bus.grant = 1'b1;

    // valid bits, all slots empty after reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else begin
            if (bus.op == cam_ctrl_pkg::OP_INSERT) begin
                valid[bus.addr] <= 1'b1;
            end else if (bus.op == cam_ctrl_pkg::OP_DELETE) begin
                valid[bus.addr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.op == cam_ctrl_pkg::OP_INSERT) begin
            tgt_mem[bus.addr] <= bus.target;
        end
    end

    // registered read, a miss returns a zero target
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bus.hit       <= 1'b0;
            bus.rd_target <= '0;
        end else if (bus.op == cam_ctrl_pkg::OP_READ) begin
            bus.hit       <= valid[bus.addr];
            bus.rd_target <= valid[bus.addr] ? tgt_mem[bus.addr] : '0;
        end
    end

endmodule : cam_table_ram

`default_nettype wire

// ==== logic/cam_table_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_table_arbiter #(
    parameter int KEY_WIDTH    = cam_cfg_pkg::KEY_WIDTH_DEF,
    parameter int TARGET_WIDTH = cam_cfg_pkg::TARGET_WIDTH_DEF
) (
    input  logic        clk,
    input  logic        rstn,
    cam_table_if.memory    upd,
    cam_table_if.memory    lkp,
    cam_table_if.requester mem
);

    localparam int DEPTH      = 2**KEY_WIDTH - cam_cfg_pkg::KEY_BASE;
    localparam int ADDR_WIDTH = $clog2(DEPTH);

    logic                    upd_req;
    logic                    lkp_req;
    logic                    upd_gnt;
    logic                    lkp_gnt;
    logic                    rd_to_upd;
    logic [ADDR_WIDTH-1:0]   sel_addr;
    logic [TARGET_WIDTH-1:0] sel_target;

    // fixed priority, update first
    assign upd_req   = (upd.op != cam_ctrl_pkg::OP_NONE);
    assign lkp_req   = (lkp.op != cam_ctrl_pkg::OP_NONE);
    assign upd_gnt   = upd_req && mem.grant;
    assign lkp_gnt   = lkp_req && !upd_req && mem.grant;
    assign upd.grant = upd_gnt;
    assign lkp.grant = lkp_gnt;

    assign sel_addr   = upd_gnt ? upd.addr : lkp.addr;
    assign sel_target = upd_gnt ? upd.target : lkp.target;
    assign mem.op     = upd_gnt ? upd.op : (lkp_gnt ? lkp.op : cam_ctrl_pkg::OP_NONE);
    assign mem.addr   = sel_addr;
    assign mem.target = sel_target;

    // owner of the last granted read, read data follows it
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_to_upd <= 1'b0;
        end else if (mem.op == cam_ctrl_pkg::OP_READ) begin
            rd_to_upd <= upd_gnt;
        end
    end

    assign upd.hit       = rd_to_upd && mem.hit;
    assign upd.rd_target = rd_to_upd ? mem.rd_target : '0;
    assign lkp.hit       = !rd_to_upd && mem.hit;
    assign lkp.rd_target = rd_to_upd ? '0 : mem.rd_target;

    // only a pending update may hold off a lookup read
    a_read_refused_for_update : assert property (@(posedge clk) disable iff (!rstn)
        (lkp_req && !lkp.grant) |-> upd_req);

endmodule : cam_table_arbiter

`default_nettype wire

// ==== logic/cam_update_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_update_ctrl #(
    parameter int KEY_WIDTH    = cam_cfg_pkg::KEY_WIDTH_DEF,
    parameter int TARGET_WIDTH = cam_cfg_pkg::TARGET_WIDTH_DEF
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [KEY_WIDTH-1:0]    write_key,
    input  logic [TARGET_WIDTH-1:0] write_target,
    input  logic                    write_enable,
    input  logic                    write_delete,
    output logic                    write_busy,
    cam_table_if.requester          bus
);

    localparam int DEPTH      = 2**KEY_WIDTH - cam_cfg_pkg::KEY_BASE;
    localparam int ADDR_WIDTH = $clog2(DEPTH);

    cam_ctrl_pkg::upd_state_e state;
    cam_ctrl_pkg::upd_state_e state_next;
    cam_ctrl_pkg::upd_state_e restart;

    logic [KEY_WIDTH-1:0]    key_q;
    logic [TARGET_WIDTH-1:0] target_q;
    logic                    strobe;
    logic                    key_in_range;

    assign strobe  = write_enable | write_delete;
    // insert wins when both strobes come together
    assign restart = write_enable ? cam_ctrl_pkg::UPD_INSERT_1 : cam_ctrl_pkg::UPD_DELETE_1;

    ////////////////////////////////////////////////////////////////////////////
    // update FSM
    ////////////////////////////////////////////////////////////////////////////

    // a new strobe always restarts, a pending *_2 write still commits
    always_comb begin
        case (state)
            cam_ctrl_pkg::UPD_INIT:     state_next = cam_ctrl_pkg::UPD_IDLE;
            cam_ctrl_pkg::UPD_IDLE:     state_next = strobe ? restart : cam_ctrl_pkg::UPD_IDLE;
            cam_ctrl_pkg::UPD_INSERT_1: state_next = strobe ? restart : cam_ctrl_pkg::UPD_INSERT_2;
            cam_ctrl_pkg::UPD_INSERT_2: state_next = strobe ? restart : cam_ctrl_pkg::UPD_IDLE;
            cam_ctrl_pkg::UPD_DELETE_1: state_next = strobe ? restart : cam_ctrl_pkg::UPD_DELETE_2;
            cam_ctrl_pkg::UPD_DELETE_2: state_next = strobe ? restart : cam_ctrl_pkg::UPD_IDLE;
            default:                    state_next = cam_ctrl_pkg::UPD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= cam_ctrl_pkg::UPD_INIT;
            write_busy <= 1'b1;
        end else begin
            state      <= state_next;
            write_busy <= (state_next != cam_ctrl_pkg::UPD_IDLE) ||
                          (state != cam_ctrl_pkg::UPD_IDLE);
        end
    end

    // capture the operands with the strobe
    always_ff @(posedge clk) begin
        if (strobe && state != cam_ctrl_pkg::UPD_INIT) begin
            key_q    <= write_key;
            target_q <= write_target;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // table write request
    ////////////////////////////////////////////////////////////////////////////

    assign key_in_range = (key_q >= cam_cfg_pkg::KEY_BASE);

    always_comb begin
        bus.op = cam_ctrl_pkg::OP_NONE;
        if (key_in_range) begin
            if (state == cam_ctrl_pkg::UPD_INSERT_2) begin
                bus.op = cam_ctrl_pkg::OP_INSERT;
            end else if (state == cam_ctrl_pkg::UPD_DELETE_2) begin
                bus.op = cam_ctrl_pkg::OP_DELETE;
            end
        end
    end

    assign bus.addr   = ADDR_WIDTH'(key_q - cam_cfg_pkg::KEY_BASE);
    assign bus.target = target_q;

    // a write lands two edges after the strobe that asked for it
    a_insert_from_strobe : assert property (@(posedge clk) disable iff (!rstn)
        (bus.op == cam_ctrl_pkg::OP_INSERT) |-> $past(write_enable, 2) && $past(!strobe));

    a_delete_from_strobe : assert property (@(posedge clk) disable iff (!rstn)
        (bus.op == cam_ctrl_pkg::OP_DELETE) |->
        $past(write_delete && !write_enable, 2) && $past(!strobe));

    // the arbiter must never drop an update
    a_write_granted : assert property (@(posedge clk) disable iff (!rstn)
        (bus.op != cam_ctrl_pkg::OP_NONE) |-> bus.grant);

endmodule : cam_update_ctrl

`default_nettype wire

// ==== logic/cam_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_lookup #(
    parameter int KEY_WIDTH    = cam_cfg_pkg::KEY_WIDTH_DEF,
    parameter int TARGET_WIDTH = cam_cfg_pkg::TARGET_WIDTH_DEF
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [KEY_WIDTH-1:0]    compare_key,
    input  logic                    write_busy,
    output logic                    match,
    output logic [TARGET_WIDTH-1:0] match_target,
    output logic                    match_valid,
    cam_table_if.requester          bus
);

    localparam int DEPTH      = 2**KEY_WIDTH - cam_cfg_pkg::KEY_BASE;
    localparam int ADDR_WIDTH = $clog2(DEPTH);
    // edges a key must stay put before its result counts
    localparam int STABLE_LAT = 1;
    localparam int CNT_WIDTH  = $clog2(STABLE_LAT + 1);

    logic [KEY_WIDTH-1:0] key_q;
    logic [CNT_WIDTH-1:0] stable_cnt;
    logic                 key_changed;
    logic                 key_stable;
    logic                 key_in_range;
    logic                 rd_ok;

    assign key_changed  = (compare_key != key_q);
    assign key_stable   = (stable_cnt == CNT_WIDTH'(STABLE_LAT));
    assign key_in_range = (compare_key >= cam_cfg_pkg::KEY_BASE);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            key_q      <= '0;
            stable_cnt <= '0;
            rd_ok      <= 1'b0;
        end else begin
            key_q <= compare_key;
            if (key_changed) begin
                stable_cnt <= '0;
            end else if (!key_stable) begin
                stable_cnt <= stable_cnt + 1'b1;
            end
            // out-of-range keys need no read, only a quiet table
            rd_ok <= !write_busy && (!key_in_range || bus.grant);
        end
    end

    // read the current slot every cycle
    assign bus.op     = key_in_range ? cam_ctrl_pkg::OP_READ : cam_ctrl_pkg::OP_NONE;
    assign bus.addr   = ADDR_WIDTH'(compare_key - cam_cfg_pkg::KEY_BASE);
    assign bus.target = '0;

    // drops in the same cycle the key moves
    assign match_valid  = !key_changed && key_stable && rd_ok;
    assign match        = key_in_range && bus.hit;
    assign match_target = key_in_range ? bus.rd_target : '0;

    // a valid result needs a quiet table and a key held over two edges
    a_valid_not_busy : assert property (@(posedge clk) disable iff (!rstn)
        match_valid |-> $past(!write_busy) && ($past(compare_key, 2) == compare_key));

endmodule : cam_lookup

`default_nettype wire

// ==== logic/cam_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_top #(
    parameter int KEY_WIDTH    = cam_cfg_pkg::KEY_WIDTH_DEF,
    parameter int TARGET_WIDTH = cam_cfg_pkg::TARGET_WIDTH_DEF
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [KEY_WIDTH-1:0]    write_key,
    input  logic [TARGET_WIDTH-1:0] write_target,
    input  logic                    write_enable,
    input  logic                    write_delete,
    input  logic [KEY_WIDTH-1:0]    compare_key,
    output logic                    match,
    output logic [TARGET_WIDTH-1:0] match_target,
    output logic                    match_valid,
    output logic                    write_busy
);

    ////////////////////////////////////////////////////////////////////////////
    // table port buses
    ////////////////////////////////////////////////////////////////////////////

    cam_table_if #(.KEY_WIDTH(KEY_WIDTH), .TARGET_WIDTH(TARGET_WIDTH)) upd_bus ();
    cam_table_if #(.KEY_WIDTH(KEY_WIDTH), .TARGET_WIDTH(TARGET_WIDTH)) lkp_bus ();
    cam_table_if #(.KEY_WIDTH(KEY_WIDTH), .TARGET_WIDTH(TARGET_WIDTH)) mem_bus ();

    cam_update_ctrl #(.KEY_WIDTH(KEY_WIDTH), .TARGET_WIDTH(TARGET_WIDTH)) u_update_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .write_key    (write_key),
        .write_target (write_target),
        .write_enable (write_enable),
        .write_delete (write_delete),
        .write_busy   (write_busy),
        .bus          (upd_bus)
    );

    // lookup results are held back while an update runs
    cam_lookup #(.KEY_WIDTH(KEY_WIDTH), .TARGET_WIDTH(TARGET_WIDTH)) u_lookup (
        .clk          (clk),
        .rstn         (rstn),
        .compare_key  (compare_key),
        .write_busy   (write_busy),
        .match        (match),
        .match_target (match_target),
        .match_valid  (match_valid),
        .bus          (lkp_bus)
    );

    cam_table_arbiter #(.KEY_WIDTH(KEY_WIDTH), .TARGET_WIDTH(TARGET_WIDTH)) u_arbiter (
        .clk  (clk),
        .rstn (rstn),
        .upd  (upd_bus),
        .lkp  (lkp_bus),
        .mem  (mem_bus)
    );

    cam_table_ram #(.KEY_WIDTH(KEY_WIDTH), .TARGET_WIDTH(TARGET_WIDTH)) u_table_ram (
        .clk  (clk),
        .rstn (rstn),
        .bus  (mem_bus)
    );

endmodule : cam_top

`default_nettype wire

// ==== include/cam_tb_tasks.svh ====
`ifndef CAM_TB_TASKS_SVH
`define CAM_TB_TASKS_SVH

// reference model, indexed by the full key
logic                    model_valid  [2**KEY_WIDTH];
logic [TARGET_WIDTH-1:0] model_target [2**KEY_WIDTH];

////////////////////////////////////////////////////////////////////////////
// host access helpers
////////////////////////////////////////////////////////////////////////////

task automatic wait_not_busy();
    int n = 0;
    while (write_busy && n < 10) begin
        @(negedge clk);
        n++;
    end
    if (write_busy) report_error("write_busy stayed high after an update");
endtask

// one strobe, then wait for the update to finish
task automatic strobe_update(input logic [KEY_WIDTH-1:0] key,
                             input logic [TARGET_WIDTH-1:0] tgt, input logic del);
    @(negedge clk);
    wait_not_busy();
    write_key    = key;
    write_target = tgt;
    write_enable = !del;
    write_delete = del;
    @(negedge clk);
    write_enable = 1'b0;
    write_delete = 1'b0;
    wait_not_busy();
    // keys below the base are never stored
    if (key >= cam_cfg_pkg::KEY_BASE) begin
        model_valid[key] = !del;
        if (!del) model_target[key] = tgt;
    end
endtask

task automatic do_insert(input logic [KEY_WIDTH-1:0] key, input logic [TARGET_WIDTH-1:0] tgt);
    strobe_update(key, tgt, 1'b0);
endtask

task automatic do_delete(input logic [KEY_WIDTH-1:0] key);
    strobe_update(key, '0, 1'b1);
endtask

task automatic do_lookup(input string test_name, input logic [KEY_WIDTH-1:0] key);
    int   n = 0;
    logic exp_hit;
    @(negedge clk);
    compare_key = key;
    do begin
        @(negedge clk);
        n++;
    end while (!match_valid && n < 6);
    exp_hit = model_valid[key];
    if (!match_valid) begin
        report_error($sformatf("%s: match_valid never rose for key %0h", test_name, key));
    end else begin
        check_value(test_name, exp_hit, match);
        check_value(test_name, exp_hit ? model_target[key] : '0, match_target);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////////////////////

task automatic test_reset();
    int n = 0;
    for (int k = 0; k < 2**KEY_WIDTH; k++) begin
        model_valid[k]  = 1'b0;
        model_target[k] = '0;
    end
    rstn = 1'b0;
    repeat (16) begin
        @(negedge clk);
        check_value("reset busy", 1, write_busy);
        check_value("reset valid", 0, match_valid);
    end
    rstn = 1'b1;
    while (write_busy && n < 3) begin
        @(negedge clk);
        n++;
    end
    check_value("reset busy release", 0, write_busy);
    for (int k = cam_cfg_pkg::KEY_BASE; k < 2**KEY_WIDTH; k++) begin
        do_lookup("reset lookup", KEY_WIDTH'(k));
    end
endtask

task automatic test_insert_lookup();
    do_insert(4'h4, 4'h3);
    do_insert(4'h7, 4'h9);
    do_insert(4'hA, 4'h5);
    do_insert(4'hF, 4'hC);
    do_lookup("insert lookup 4", 4'h4);
    do_lookup("insert lookup 7", 4'h7);
    do_lookup("insert lookup A", 4'hA);
    do_lookup("insert lookup F", 4'hF);
    do_insert(4'h7, 4'hE);
    do_lookup("overwrite 7", 4'h7);
endtask

task automatic test_delete();
    do_delete(4'hA);
    do_lookup("delete A", 4'hA);
    do_lookup("delete keeps 4", 4'h4);
    do_lookup("delete keeps 7", 4'h7);
    do_lookup("delete keeps F", 4'hF);
endtask

task automatic test_out_of_range();
    for (int k = 0; k < cam_cfg_pkg::KEY_BASE; k++) begin
        do_insert(KEY_WIDTH'(k), TARGET_WIDTH'(k + 1));
    end
    for (int k = 0; k < 2**KEY_WIDTH; k++) begin
        do_lookup("out of range", KEY_WIDTH'(k));
    end
endtask

task automatic test_valid_timing();
    logic prev_busy = 1'b0;
    logic seen_busy = 1'b0;
    int   n = 0;
    do_lookup("timing settle", 4'h4);
    compare_key = 4'h7;
    #(CLK_PERIOD/4);
    check_value("valid drop", 0, match_valid);
    @(negedge clk);
    check_value("valid edge 1", 0, match_valid);
    @(negedge clk);
    check_value("valid edge 2", 1, match_valid);
    // insert into the watched slot, results held back while busy
    write_key    = 4'h7;
    write_target = 4'h2;
    write_enable = 1'b1;
    do begin
        @(negedge clk);
        write_enable = 1'b0;
        if (prev_busy) check_value("valid while busy", 0, match_valid);
        seen_busy = seen_busy | write_busy;
        prev_busy = write_busy;
        n++;
    end while (n < 10 && (write_busy || !match_valid));
    model_valid[7]  = 1'b1;
    model_target[7] = 4'h2;
    check_value("busy during insert", 1, seen_busy);
    do_lookup("timing insert", 4'h7);
endtask

task automatic test_random();
    logic [15:0] op;
    logic [15:0] key;
    logic [15:0] tgt;
    for (int i = 0; i < 60; i++) begin
        take_rand_bits(2, op);
        take_rand_bits(KEY_WIDTH, key);
        take_rand_bits(TARGET_WIDTH, tgt);
        case (op[1:0])
            2'd0:    do_insert(key[KEY_WIDTH-1:0], tgt[TARGET_WIDTH-1:0]);
            2'd1:    do_delete(key[KEY_WIDTH-1:0]);
            default: do_lookup("random lookup", key[KEY_WIDTH-1:0]);
        endcase
    end
endtask

`endif

// ==== testbench/cam_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_tb;

    localparam int KEY_WIDTH    = cam_cfg_pkg::KEY_WIDTH_DEF;
    localparam int TARGET_WIDTH = cam_cfg_pkg::TARGET_WIDTH_DEF;
    localparam int CLK_PERIOD   = 100;
    // all tests together need roughly 700 cycles
    localparam int MAX_CYCLES   = 4000;

    logic                    clk;
    logic                    rstn;
    logic [KEY_WIDTH-1:0]    write_key;
    logic [TARGET_WIDTH-1:0] write_target;
    logic                    write_enable;
    logic                    write_delete;
    logic [KEY_WIDTH-1:0]    compare_key;
    logic                    match;
    logic [TARGET_WIDTH-1:0] match_target;
    logic                    match_valid;
    logic                    write_busy;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [15:0] lfsr_state;

    cam_top #(.KEY_WIDTH(KEY_WIDTH), .TARGET_WIDTH(TARGET_WIDTH)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus source and checking
    ////////////////////////////////////////////////////////////////////////////

    // fibonacci taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_rand_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val        = {val[14:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Fail %s expected %0h actual %0h", test_name, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("Error: %s", msg);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

`include "cam_tb_tasks.svh"

    initial begin
        rstn         = 1'b0;
        write_key    = '0;
        write_target = '0;
        write_enable = 1'b0;
        write_delete = 1'b0;
        compare_key  = '0;
        lfsr_state   = 16'd38388;
        test_reset();
        test_insert_lookup();
        test_delete();
        test_out_of_range();
        test_valid_timing();
        test_random();
        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : cam_tb

`default_nettype wire

// ==== flist.f ====
+incdir+include
logic/cam_cfg_pkg.sv
logic/cam_ctrl_pkg.sv
logic/cam_table_if.sv
logic/cam_table_ram.sv
logic/cam_table_arbiter.sv
logic/cam_update_ctrl.sv
logic/cam_lookup.sv
logic/cam_top.sv
testbench/cam_tb.sv
